//--- rtl/bus_arb_pkg.sv
`default_nettype none

package bus_arb_pkg;

   // Six requesters share the system bus
   localparam int n_req = 6;

   // Width of a requester index
   localparam int idx_w = 3;

   // Bit position of each requester in br, bg and cntrlr_ack
   localparam logic [idx_w-1:0] idx_icache = 3'd0;
   localparam logic [idx_w-1:0] idx_dcache = 3'd1;
   localparam logic [idx_w-1:0] idx_mem    = 3'd2;
   localparam logic [idx_w-1:0] idx_kbd    = 3'd3;
   localparam logic [idx_w-1:0] idx_dma    = 3'd4;
   localparam logic [idx_w-1:0] idx_spare  = 3'd5;

   // Priority from highest to lowest is mem, dcache, icache, kbd, dma, spare

   // Named view of one request or grant word
   // First field is the MSB, so icache lands on bit 0
   typedef struct packed {
      logic spare;
      logic dma;
      logic kbd;
      logic mem;
      logic dcache;
      logic icache;
   } req_bits_s;

   // One six-bit word seen either as a vector or by requester name
   typedef union packed {
      logic [n_req-1:0] vec;
      req_bits_s        bits;
   } req_word_u;

   // One-hot arbiter state
   typedef enum logic [1:0] {
      arb_idle = 2'b01,
      arb_busy = 2'b10
   } arb_state_e;

endpackage

`default_nettype wire

//--- rtl/grant_if.sv
`timescale 1ns/1ps
`default_nettype none

// Grant state from the arbiter to the status block
interface grant_if;

   // Current one-hot grant or zero when the bus is free
   bus_arb_pkg::req_word_u grant;

   bus_arb_pkg::arb_state_e state;

   // Index of the granted requester while busy
   logic [bus_arb_pkg::idx_w-1:0] owner;

   // High for the cycle after each grant change
   logic switch_pulse;

   modport arb (
      output grant,
      output state,
      output owner,
      output switch_pulse
   );

   modport stat (
      input grant,
      input state,
      input owner,
      input switch_pulse
   );

endinterface

`default_nettype wire

//--- rtl/ack_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded acknowledge lines from the collector to the status block
interface ack_if;

   // At least one controller acknowledged this cycle
   logic ack_any;

   // Two or more controllers acknowledged together
   logic multi_ack;

   // Lowest acknowledging line
   logic [bus_arb_pkg::idx_w-1:0] ack_owner;

   // Raw acknowledge lines
   logic [bus_arb_pkg::n_req-1:0] ack_vec;

   modport coll (
      output ack_any,
      output multi_ack,
      output ack_owner,
      output ack_vec
   );

   modport stat (
      input ack_any,
      input multi_ack,
      input ack_owner,
      input ack_vec
   );

endinterface

`default_nettype wire

//--- rtl/grant_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module grant_arbiter (
   input  logic                          bus_clk,
   input  logic                          rst_n,
   input  logic [bus_arb_pkg::n_req-1:0] br,
   grant_if.arb                          gnt
);

   bus_arb_pkg::req_word_u  req;
   bus_arb_pkg::req_word_u  pick;
   bus_arb_pkg::req_word_u  grant_d;
   bus_arb_pkg::req_word_u  grant_q;
   bus_arb_pkg::arb_state_e state_d;
   bus_arb_pkg::arb_state_e state_q;

   logic [bus_arb_pkg::idx_w-1:0] owner_d;
   logic [bus_arb_pkg::idx_w-1:0] owner_q;

   logic any_req;
   logic done;
   logic busy_switch;
   logic idle_switch;
   logic switch_master;
   logic switch_q;

   assign req.vec = br;
   assign any_req = |req.vec;

   // Holder has dropped its request
   assign done = |(grant_q.vec & ~req.vec);

   // New master is picked on leaving idle or when the holder is done
   assign busy_switch   = (state_q == bus_arb_pkg::arb_busy) && any_req && done;
   assign idle_switch   = (state_q == bus_arb_pkg::arb_idle) && any_req;
   assign switch_master = busy_switch || idle_switch;

   // Fixed priority picker
   always_comb begin
      pick = '0;
      if (req.bits.mem) begin
         pick.bits.mem = 1'b1;
      end else if (req.bits.dcache) begin
         pick.bits.dcache = 1'b1;
      end else if (req.bits.icache) begin
         pick.bits.icache = 1'b1;
      end else if (req.bits.kbd) begin
         pick.bits.kbd = 1'b1;
      end else if (req.bits.dma) begin
         pick.bits.dma = 1'b1;
      end else if (req.bits.spare) begin
         pick.bits.spare = 1'b1;
      end
   end

   // No requests at all clears the master
   always_comb begin
      if (!any_req) begin
         grant_d = '0;
      end else if (switch_master) begin
         grant_d = pick;
      end else begin
         grant_d = grant_q;
      end
   end

   assign state_d = any_req ? bus_arb_pkg::arb_busy : bus_arb_pkg::arb_idle;

   // One-hot grant to owner index
   always_comb begin
      owner_d = '0;
      if (grant_d.bits.icache) begin
         owner_d = bus_arb_pkg::idx_icache;
      end else if (grant_d.bits.dcache) begin
         owner_d = bus_arb_pkg::idx_dcache;
      end else if (grant_d.bits.mem) begin
         owner_d = bus_arb_pkg::idx_mem;
      end else if (grant_d.bits.kbd) begin
         owner_d = bus_arb_pkg::idx_kbd;
      end else if (grant_d.bits.dma) begin
         owner_d = bus_arb_pkg::idx_dma;
      end else if (grant_d.bits.spare) begin
         owner_d = bus_arb_pkg::idx_spare;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         state_q  <= bus_arb_pkg::arb_idle;
         grant_q  <= '0;
         owner_q  <= '0;
         switch_q <= 1'b0;
      end else begin
         state_q  <= state_d;
         grant_q  <= grant_d;
         owner_q  <= owner_d;
         switch_q <= (grant_d.vec != grant_q.vec);
      end
   end

   assign gnt.grant        = grant_q;
   assign gnt.state        = state_q;
   assign gnt.owner        = owner_q;
   assign gnt.switch_pulse = switch_q;

endmodule

`default_nettype wire

//--- rtl/ack_collector.sv
`timescale 1ns/1ps
`default_nettype none

module ack_collector (
   input  logic [bus_arb_pkg::n_req-1:0] cntrlr_ack,
   ack_if.coll                           ack
);

   logic [bus_arb_pkg::n_req-1:0] ack_less_one;
   logic [bus_arb_pkg::idx_w-1:0] low_idx;

   // Unified acknowledge
   assign ack.ack_any = |cntrlr_ack;

   // Clearing the lowest set bit leaves something only if two or more were set
   assign ack_less_one  = cntrlr_ack - 1'b1;
   assign ack.multi_ack = |(cntrlr_ack & ack_less_one);

   // Lowest acknowledging line wins, so scan downward and let later hits overwrite
   always_comb begin
      low_idx = '0;
      for (int i = bus_arb_pkg::n_req - 1; i >= 0; i--) begin
         if (cntrlr_ack[i]) begin
            low_idx = i[bus_arb_pkg::idx_w-1:0];
         end
      end
   end

   assign ack.ack_owner = low_idx;
   assign ack.ack_vec   = cntrlr_ack;

endmodule

`default_nettype wire

//--- rtl/bus_status.sv
`timescale 1ns/1ps
`default_nettype none

module bus_status (
   input  logic  bus_clk,
   input  logic  rst_n,
   grant_if.stat gnt,
   ack_if.stat   ack,
   output logic  bus_ack,
   output logic  bus_busy,
   output logic  bus_error
);

   logic on_idle;
   logic foreign;
   logic stray;
   logic violation;
   logic error_q;

   assign bus_ack  = ack.ack_any;
   assign bus_busy = |gnt.grant.vec;

   assign on_idle = (gnt.state == bus_arb_pkg::arb_idle);

   // Acknowledge index does not match the granted requester
   assign foreign = (ack.ack_owner != gnt.owner);

   // Any acknowledge line outside the grant vector
   assign stray = |(ack.ack_vec & ~gnt.grant.vec);

   assign violation = ack.ack_any && (ack.multi_ack || foreign || stray || on_idle);

   // Error pulse one cycle after the offending acknowledge
   always_ff @(posedge bus_clk) begin
      if (!rst_n) begin
         error_q <= 1'b0;
      end else begin
         error_q <= violation;
      end
   end

   assign bus_error = error_q;

endmodule

`default_nettype wire

//--- rtl/bus_arbiter_top.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter_top (
   input  logic                          bus_clk,
   input  logic                          rst_n,
   input  logic [bus_arb_pkg::n_req-1:0] br,
   input  logic [bus_arb_pkg::n_req-1:0] cntrlr_ack,
   output logic [bus_arb_pkg::n_req-1:0] bg,
   output logic                          bus_ack,
   output logic                          bus_busy,
   output logic                          bus_error
);

   grant_if gnt_bus ();
   ack_if   ack_bus ();

   // Grant side
   grant_arbiter arbiter_u (
      .bus_clk (bus_clk),
      .rst_n   (rst_n),
      .br      (br),
      .gnt     (gnt_bus.arb)
   );

   // Purely combinational acknowledge side
   ack_collector collector_u (
      .cntrlr_ack (cntrlr_ack),
      .ack        (ack_bus.coll)
   );

   bus_status status_u (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .gnt       (gnt_bus.stat),
      .ack       (ack_bus.stat),
      .bus_ack   (bus_ack),
      .bus_busy  (bus_busy),
      .bus_error (bus_error)
   );

   assign bg = gnt_bus.grant.vec;

endmodule

`default_nettype wire

//--- tests/bus_arbiter_chk.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter_chk (
   input logic                          bus_clk,
   input logic                          rst_n,
   input logic [bus_arb_pkg::n_req-1:0] br,
   input logic [bus_arb_pkg::n_req-1:0] cntrlr_ack,
   input logic [bus_arb_pkg::n_req-1:0] bg,
   input logic                          bus_ack,
   input logic                          bus_busy,
   input logic                          bus_error
);

   // Count of assertion failures so far
   int fail_count = 0;

   logic violation;

   // Acknowledge from several controllers, from a non-granted one, or on an idle bus
   assign violation = (|cntrlr_ack) &&
                      (!$onehot(cntrlr_ack) || ((cntrlr_ack & ~bg) != '0));

   reset_clear: assert property (@(posedge bus_clk)
      !rst_n |=> (bg == '0 && !bus_busy && !bus_error))
      else begin
         fail_count++;
         $error("bg or bus status not cleared by reset");
      end

   grant_onehot: assert property (@(posedge bus_clk) disable iff (!rst_n)
      $onehot0(bg))
      else begin
         fail_count++;
         $error("bg is neither one-hot nor zero: %b", bg);
      end

   // Holder keeps the bus while its request stays high
   hold_grant: assert property (@(posedge bus_clk) disable iff (!rst_n)
      ((bg & br) != '0) |=> $stable(bg))
      else begin
         fail_count++;
         $error("grant changed while the holder still requested");
      end

   busy_tracks_grant: assert property (@(posedge bus_clk) disable iff (!rst_n)
      bus_busy == (bg != '0))
      else begin
         fail_count++;
         $error("bus_busy does not follow the grant");
      end

   ack_unified: assert property (@(posedge bus_clk) disable iff (!rst_n)
      bus_ack == (|cntrlr_ack))
      else begin
         fail_count++;
         $error("bus_ack is not the OR of the acknowledge lines");
      end

   error_after_violation: assert property (@(posedge bus_clk) disable iff (!rst_n)
      violation |=> bus_error)
      else begin
         fail_count++;
         $error("protocol violation not flagged on bus_error");
      end

   no_spurious_error: assert property (@(posedge bus_clk) disable iff (!rst_n)
      !violation |=> !bus_error)
      else begin
         fail_count++;
         $error("bus_error raised without a protocol violation");
      end

endmodule

bind bus_arbiter_top bus_arbiter_chk chk0 (
   .bus_clk    (bus_clk),
   .rst_n      (rst_n),
   .br         (br),
   .cntrlr_ack (cntrlr_ack),
   .bg         (bg),
   .bus_ack    (bus_ack),
   .bus_busy   (bus_busy),
   .bus_error  (bus_error)
);

`default_nettype wire

//--- tests/tb_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_arbiter;

   logic                          bus_clk;
   logic                          rst_n;
   logic                          rst_next;
   logic [bus_arb_pkg::n_req-1:0] br;
   logic [bus_arb_pkg::n_req-1:0] cntrlr_ack;
   logic [bus_arb_pkg::n_req-1:0] bg;
   logic                          bus_ack;
   logic                          bus_busy;
   logic                          bus_error;

   // Reference model state
   logic [bus_arb_pkg::n_req-1:0] exp_bg;
   logic                          exp_err;

   logic [7:0] lfsr;
   string      test_name;
   int         test_errors;
   int         chk_base;
   int         tests_passed;
   int         tests_failed;

   bus_arbiter_top dut0 (
      .bus_clk    (bus_clk),
      .rst_n      (rst_n),
      .br         (br),
      .cntrlr_ack (cntrlr_ack),
      .bg         (bg),
      .bus_ack    (bus_ack),
      .bus_busy   (bus_busy),
      .bus_error  (bus_error)
   );

   initial begin
      bus_clk = 1'b0;
      forever begin
         #5 bus_clk = ~bus_clk;
      end
   end

   // Watchdog for the whole run
   initial begin
      #100000;
      $display("Simulation did not finish within its time limit");
      $display("Checks failed");
      $finish;
   end

   // x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   task automatic rand_bits(input int n, output logic [bus_arb_pkg::n_req-1:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[bus_arb_pkg::n_req-2:0], lfsr[7]};
      end
   endtask

   // Priority mem, dcache, icache, kbd, dma, spare
   function automatic logic [bus_arb_pkg::n_req-1:0] pick_highest(
      input logic [bus_arb_pkg::n_req-1:0] req);
      int order [6] = '{2, 1, 0, 3, 4, 5};
      logic [bus_arb_pkg::n_req-1:0] res;
      res = '0;
      // Lowest priority first so higher ones overwrite
      for (int k = 5; k >= 0; k--) begin
         if (req[order[k]]) begin
            res = '0;
            res[order[k]] = 1'b1;
         end
      end
      return res;
   endfunction

   function automatic logic [bus_arb_pkg::n_req-1:0] next_grant(
      input logic [bus_arb_pkg::n_req-1:0] cur, input logic [bus_arb_pkg::n_req-1:0] req);
      if (req == '0) begin
         return '0;
      end
      if (cur == '0 || (cur & ~req) != '0) begin
         return pick_highest(req);
      end
      return cur;
   endfunction

   function automatic logic protocol_error(
      input logic [bus_arb_pkg::n_req-1:0] gnt, input logic [bus_arb_pkg::n_req-1:0] ack);
      int hits = $countones(ack);
      return (hits > 1) || (hits == 1 && (ack & gnt) == '0);
   endfunction

   task automatic compare_value(input string name, input logic [bus_arb_pkg::n_req-1:0] exp,
                                input logic [bus_arb_pkg::n_req-1:0] act);
      if (act !== exp) begin
         $display("[ERROR] %0d ns %s expected %b actual %b", $time, name, exp, act);
         test_errors++;
      end
   endtask

   // Update the model at the edge, drive, then compare mid-cycle
   task automatic step_cycle(input logic [bus_arb_pkg::n_req-1:0] next_br,
                             input logic [bus_arb_pkg::n_req-1:0] next_ack);
      @(posedge bus_clk);
      if (!rst_n) begin
         exp_bg  = '0;
         exp_err = 1'b0;
      end else begin
         exp_err = protocol_error(exp_bg, cntrlr_ack);
         exp_bg  = next_grant(exp_bg, br);
      end
      #1;
      rst_n      = rst_next;
      br         = next_br;
      cntrlr_ack = next_ack;
      #4;
      compare_value("bg", exp_bg, bg);
      compare_value("bus_busy", exp_bg != '0, bus_busy);
      compare_value("bus_ack", |next_ack, bus_ack);
      compare_value("bus_error", exp_err, bus_error);
   endtask

   task automatic wait_grant(input int idx, input int limit);
      int count = 0;
      while (bg[idx] !== 1'b1 && count < limit) begin
         step_cycle(br, '0);
         count++;
      end
      if (bg[idx] !== 1'b1) begin
         $display("Timed out after %0d cycles waiting for a grant to requester %0d",
                  limit, idx);
         test_errors++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_errors = 0;
      chk_base    = dut0.chk0.fail_count;
   endtask

   task automatic end_test();
      int chk_new;
      chk_new = dut0.chk0.fail_count - chk_base;
      if (test_errors == 0 && chk_new == 0) begin
         tests_passed++;
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: FAILED, %0d model errors, %0d assertion failures",
                  test_name, test_errors, chk_new);
      end
   endtask

   initial begin
      logic [bus_arb_pkg::n_req-1:0] r_req;
      logic [bus_arb_pkg::n_req-1:0] r_sel;
      logic [bus_arb_pkg::n_req-1:0] r_ack;
      br           = '0;
      cntrlr_ack   = '0;
      rst_n        = 1'b0;
      rst_next     = 1'b0;
      exp_bg       = '0;
      exp_err      = 1'b0;
      lfsr         = 8'd70;
      test_errors  = 0;
      tests_passed = 0;
      tests_failed = 0;

      begin_test("reset");
      repeat (4) step_cycle('0, '0);
      rst_next = 1'b1;
      step_cycle('0, '0);
      step_cycle('0, '0);
      end_test();

      // Each requester alone, then random mixes, always from a free bus
      begin_test("free_bus");
      for (int i = 0; i < 14; i++) begin
         if (i < 6) begin
            r_req = '0;
            r_req[i] = 1'b1;
         end else begin
            rand_bits(6, r_req);
         end
         step_cycle(r_req, '0);
         step_cycle('0, '0);
         compare_value("bg", pick_highest(r_req), bg);
      end
      step_cycle('0, '0);
      end_test();

      // Spare holds the bus while mem, dcache and icache wait
      begin_test("no_preempt");
      step_cycle(6'b100000, '0);
      step_cycle(6'b100000, '0);
      repeat (4) step_cycle(6'b100111, '0);
      compare_value("bg", 6'b100000, bg);
      end_test();

      begin_test("handover");
      step_cycle(6'b000111, '0);
      wait_grant(bus_arb_pkg::idx_mem, 4);
      step_cycle(6'b000011, '0);
      wait_grant(bus_arb_pkg::idx_dcache, 4);
      step_cycle(6'b000001, '0);
      wait_grant(bus_arb_pkg::idx_icache, 4);
      step_cycle('0, '0);
      step_cycle('0, '0);
      compare_value("bg", '0, bg);
      end_test();

      // Legal ack from the holder, then each violation kind
      begin_test("ack_error");
      step_cycle(6'b000100, '0);
      step_cycle(6'b000100, 6'b000100);
      step_cycle(6'b000100, 6'b000110);
      step_cycle(6'b000100, 6'b010000);
      step_cycle(6'b000100, '0);
      step_cycle('0, '0);
      step_cycle('0, '0);
      step_cycle('0, 6'b001000);
      step_cycle('0, '0);
      step_cycle('0, '0);
      end_test();

      begin_test("random");
      for (int c = 0; c < 300; c++) begin
         rand_bits(6, r_req);
         rand_bits(2, r_sel);
         // Holder usually keeps its request, so tenures last several cycles
         if (r_sel[1:0] != 2'b00) begin
            r_req = r_req | bg;
         end
         rand_bits(2, r_sel);
         if (r_sel[1:0] == 2'b10) begin
            r_ack = bg;
         end else if (r_sel[1:0] == 2'b11) begin
            rand_bits(6, r_ack);
         end else begin
            r_ack = '0;
         end
         step_cycle(r_req, r_ack);
      end
      step_cycle('0, '0);
      step_cycle('0, '0);
      end_test();

      $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
               tests_passed, tests_failed, dut0.chk0.fail_count);
      if (tests_failed == 0 && dut0.chk0.fail_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
rtl/bus_arb_pkg.sv
rtl/grant_if.sv
rtl/ack_if.sv
rtl/grant_arbiter.sv
rtl/ack_collector.sv
rtl/bus_status.sv
rtl/bus_arbiter_top.sv
tests/bus_arbiter_chk.sv
tests/tb_bus_arbiter.sv
